// File: Makefile
# Verilator build and run for the ethernet transmit testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_tx
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_TEXT ?= TEST RESULT: FAIL

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ddio_out.sv
// behavioral double data rate output register, models the vendor ddio primitive in simulation
`timescale 1ns/1ps

module ddio_out #(
  parameter int width = 5
) (
  input  logic             clock,
  input  logic             reset,
  // shown while the clock is high, first half of the cycle
  input  logic [width-1:0] data_high_phase,
  // shown while the clock is low, second half of the cycle
  input  logic [width-1:0] data_low_phase,
  output logic [width-1:0] data_out
);

  logic [width-1:0] high_reg;
  logic [width-1:0] low_reg;

  // --------------------------------------------------------------------------
  // capture, both halves on the rising edge
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      high_reg <= '0;
      low_reg  <= '0;
    end else begin
      high_reg <= data_high_phase;
      low_reg  <= data_low_phase;
    end
  end

  // --------------------------------------------------------------------------
  // phase mux
  // --------------------------------------------------------------------------
  // high phase right after the edge, then low phase until the next edge
  // so one clock cycle carries both halves in that order
  assign data_out = clock ? high_reg : low_reg;

endmodule

// File: eth_fcs_append.sv
// pads each transmit frame to the minimum length and appends the four crc-32 fcs bytes
`timescale 1ns/1ps

module eth_fcs_append #(
  parameter int min_frame_bytes = 60
) (
  input  logic                  clock,
  input  logic                  reset,
  input  eth_tx_pkg::eth_byte_t in_byte,
  output eth_tx_pkg::eth_byte_t out_byte,
  // high while pad or fcs bytes come out of this stage
  output logic                  padding
);

  // counter covers the pad limit and the fcs byte index
  localparam int count_max = (min_frame_bytes > eth_tx_pkg::fcs_len) ?
                             min_frame_bytes : eth_tx_pkg::fcs_len;
  localparam int count_w   = $clog2(count_max + 1);

  typedef enum logic [1:0] {
    st_data,
    st_pad,
    st_fcs
  } state_t;

  state_t             state;
  logic [count_w-1:0] count;
  logic [31:0]        crc;
  logic               pad_more;

  // --------------------------------------------------------------------------
  // crc-32, one byte per call, lsb first
  // --------------------------------------------------------------------------
  function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
    logic [31:0] c;
    c = crc_in ^ {24'h000000, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ eth_tx_pkg::crc_poly) : (c >> 1);
    end
    return c;
  endfunction

  // still short of the minimum, count saturates here
  assign pad_more = count < count_w'(min_frame_bytes);
  assign padding  = state != st_data;

  // --------------------------------------------------------------------------
  // data, pad and fcs sequencing
  // --------------------------------------------------------------------------
  // out_byte is registered, one cycle behind in_byte
  // crc always covers the bytes already sent, so it is ready when fcs starts
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= st_data;
      count    <= '0;
      crc      <= eth_tx_pkg::crc_init;
      out_byte <= '0;
    end else begin
      case (state)
        st_data, st_pad: begin
          if (state == st_data && in_byte.enable) begin
            // payload byte, pass straight through
            out_byte <= '{data: in_byte.data, enable: 1'b1};
            crc      <= crc_byte(crc, in_byte.data);
            if (pad_more) begin
              count <= count + 1'b1;
            end
          end else if (state == st_pad || out_byte.enable) begin
            // frame tail, either another zero byte or the first fcs byte
            if (pad_more) begin
              state    <= st_pad;
              out_byte <= '{data: 8'h00, enable: 1'b1};
              crc      <= crc_byte(crc, 8'h00);
              count    <= count + 1'b1;
            end else begin
              state    <= st_fcs;
              out_byte <= '{data: ~crc[7:0], enable: 1'b1};
              crc      <= crc >> 8;
              count    <= count_w'(1);
            end
          end else begin
            // idle
            out_byte <= '0;
          end
        end
        st_fcs: begin
          if (count != count_w'(eth_tx_pkg::fcs_len)) begin
            out_byte <= '{data: ~crc[7:0], enable: 1'b1};
            crc      <= crc >> 8;
            count    <= count + 1'b1;
          end else begin
            // last fcs byte went out, drop enable and rearm
            state    <= st_data;
            out_byte <= '0;
            count    <= '0;
            crc      <= eth_tx_pkg::crc_init;
          end
        end
        default: state <= st_data;
      endcase
    end
  end

  // the source waits for busy low, so no new frame starts during pad or fcs
  no_start_while_padding: assert property (
    @(posedge clock) disable iff (reset) padding |-> !$rose(in_byte.enable)
  ) else $error("in_byte.enable rose while pad or fcs bytes were being sent");

endmodule

// File: eth_tx_pkg.sv
// shared types and constants of the ethernet transmit path, referenced by package::name
package eth_tx_pkg;

  // --------------------------------------------------------------------------
  // stream and pin types
  // --------------------------------------------------------------------------

  // one byte on the transmit stream
  // enable is a level, high for every byte of a frame
  typedef struct packed {
    logic [7:0] data;
    logic       enable;
  } eth_byte_t;

  // one half-word on the rgmii pins, tx_en above the data nibble
  typedef struct packed {
    logic       tx_en;
    logic [3:0] tx_data;
  } rgmii_pins_t;

  // --------------------------------------------------------------------------
  // framing constants
  // --------------------------------------------------------------------------

  // seven 0x55 bytes then the 0xd5 start delimiter, first byte in the top bits
  localparam logic [63:0] preamble_bytes = 64'h55555555555555D5;

  // preamble plus delimiter byte count
  localparam int preamble_len = 8;

  // reflected crc-32 polynomial, bits shift out lsb first
  localparam logic [31:0] crc_poly = 32'hEDB88320;

  // register preset at frame start
  // the fcs on the wire is the ones' complement of the final register
  localparam logic [31:0] crc_init = 32'hFFFFFFFF;

  // number of fcs bytes after the padded payload
  localparam int fcs_len = 4;

endpackage

// File: eth_tx_top.sv
// top of the gigabit ethernet transmit path, byte stream in, rgmii pins and busy level out
`timescale 1ns/1ps

module eth_tx_top #(
  // data plus pad bytes ahead of the fcs
  parameter int min_frame_bytes = 60,
  // idle byte times after each frame
  parameter int ifg_bytes       = 12
) (
  input  logic                    clock,
  input  logic                    reset,
  input  eth_tx_pkg::eth_byte_t   in_byte,
  // source may start a frame only while this is low
  output logic                    busy,
  output eth_tx_pkg::rgmii_pins_t rgmii
);

  // --------------------------------------------------------------------------
  // stages
  // --------------------------------------------------------------------------
  eth_tx_pkg::eth_byte_t fcs_byte;
  logic                  padding;
  logic                  active;

  // pad and fcs, one cycle of latency
  eth_fcs_append #(
    .min_frame_bytes(min_frame_bytes)
  ) fcs_append_inst (
    .clock   (clock),
    .reset   (reset),
    .in_byte (in_byte),
    .out_byte(fcs_byte),
    .padding (padding)
  );

  // preamble, gap and ddr pins, eight cycles from byte to pins
  rgmii_send #(
    .ifg_bytes(ifg_bytes)
  ) rgmii_send_inst (
    .clock  (clock),
    .reset  (reset),
    .tx_byte(fcs_byte),
    .active (active),
    .rgmii  (rgmii)
  );

  // active covers send and gap, padding covers the tail of the fcs stage
  assign busy = padding | active;

endmodule

// File: rgmii_send.sv
// rgmii transmit side, adds preamble and delimiter, enforces the inter-frame gap, drives ddr pins
`timescale 1ns/1ps

module rgmii_send #(
  parameter int ifg_bytes = 12
) (
  input  logic                    clock,
  input  logic                    reset,
  input  eth_tx_pkg::eth_byte_t   tx_byte,
  // high from the first byte in until the gap has passed
  output logic                    active,
  output eth_tx_pkg::rgmii_pins_t rgmii
);

  localparam int hi_bit    = 8 * eth_tx_pkg::preamble_len - 1;
  localparam int count_max = (ifg_bytes > eth_tx_pkg::preamble_len) ?
                             ifg_bytes : eth_tx_pkg::preamble_len;
  localparam int count_w   = $clog2(count_max + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_gap
  } state_t;

  state_t                  state;
  logic [hi_bit:0]         shift_reg;
  logic [count_w-1:0]      bytes_left;
  logic                    sending;
  eth_tx_pkg::rgmii_pins_t first_half;
  eth_tx_pkg::rgmii_pins_t second_half;

  // --------------------------------------------------------------------------
  // shift register
  // --------------------------------------------------------------------------
  // idle: holds the preamble, so the first frame cycle already sends 0x55
  // sending: frame bytes enter at the bottom, oldest byte leaves at the top
  always_ff @(posedge clock) begin
    if (sending) begin
      shift_reg <= {shift_reg[hi_bit-8:0], tx_byte.data};
    end else begin
      shift_reg <= eth_tx_pkg::preamble_bytes;
    end
  end

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  // enable counts at once, so the first byte is not lost to the idle cycle
  assign sending = tx_byte.enable | (state == st_send);
  assign active  = sending | (state == st_gap);

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      bytes_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          // first frame byte arriving
          if (tx_byte.enable) begin
            state      <= st_send;
            bytes_left <= count_w'(eth_tx_pkg::preamble_len - 1);
          end
        end
        st_send: begin
          if (tx_byte.enable) begin
            // rearm the purge count on every frame byte
            bytes_left <= count_w'(eth_tx_pkg::preamble_len - 1);
          end else if (bytes_left != '0) begin
            // empty what is left in the shift register
            bytes_left <= bytes_left - 1'b1;
          end else begin
            // last byte is on its way out, start the gap
            bytes_left <= count_w'(ifg_bytes);
            state      <= st_gap;
          end
        end
        st_gap: begin
          if (bytes_left != '0) begin
            bytes_left <= bytes_left - 1'b1;
          end else begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // ddr output
  // --------------------------------------------------------------------------
  // low nibble of the oldest byte first, then its high nibble
  assign first_half  = '{tx_en: sending, tx_data: shift_reg[hi_bit-4 -: 4]};
  assign second_half = '{tx_en: sending, tx_data: shift_reg[hi_bit -: 4]};

  ddio_out #(
    .width($bits(eth_tx_pkg::rgmii_pins_t))
  ) ddio_out_inst (
    .clock          (clock),
    .reset          (reset),
    .data_high_phase(first_half),
    .data_low_phase (second_half),
    .data_out       (rgmii)
  );

  // upstream holds the next frame until active drops
  no_start_in_gap: assert property (
    @(posedge clock) disable iff (reset) (state == st_gap) |-> !$rose(tx_byte.enable)
  ) else $error("tx_byte.enable rose during the inter-frame gap");

  // the gap count is the largest load, purge count must fit below it
  gap_count_bound: assert property (
    @(posedge clock) disable iff (reset) bytes_left <= count_w'(ifg_bytes)
  ) else $error("bytes_left above ifg_bytes");

endmodule

// File: src.f
eth_tx_pkg.sv
ddio_out.sv
eth_fcs_append.sv
rgmii_send.sv
eth_tx_top.sv
tb_eth_tx.sv

// File: tb_eth_tx.sv
// testbench for eth_tx_top, sends random frames and decodes the rgmii pins back into bytes
`timescale 1ns/1ps

module tb_eth_tx;

  localparam int min_frame_bytes = 60;
  localparam int ifg_bytes       = 12;
  // cycles allowed for any single wait
  localparam int wait_limit      = 1000;

  logic                    clock;
  logic                    reset;
  eth_tx_pkg::eth_byte_t   in_byte;
  logic                    busy;
  eth_tx_pkg::rgmii_pins_t rgmii;

  // expected wire image and decoded wire image, frames kept flat with a length list
  logic [7:0] exp_bytes[$];
  int         exp_lens[$];
  logic [7:0] dec_bytes[$];
  int         dec_lens[$];

  logic [31:0] lfsr;
  int          errors;
  int          busy_errors;
  int          tests_run;
  int          tests_failed;
  int          mark;

  eth_tx_top #(
    .min_frame_bytes(min_frame_bytes),
    .ifg_bytes      (ifg_bytes)
  ) dut (
    .clock  (clock),
    .reset  (reset),
    .in_byte(in_byte),
    .busy   (busy),
    .rgmii  (rgmii)
  );

  always #5 clock = ~clock;

  // --------------------------------------------------------------------------
  // random bits and reference crc
  // --------------------------------------------------------------------------
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken, newest bit at the bottom
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // bit serial crc-32 register, message bits enter lsb first
  function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] b);
    logic        fb;
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ b[i];
      r  = {1'b0, r[31:1]};
      if (fb) begin
        r = r ^ 32'hEDB88320;
      end
    end
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // rgmii decoder
  // --------------------------------------------------------------------------
  eth_tx_pkg::rgmii_pins_t first_half;
  eth_tx_pkg::rgmii_pins_t second_half;
  logic                    in_frame;
  logic                    seen_frame;
  int                      gap_count;
  int                      cur_len;

  // sample in the middle of each clock phase, low nibble in the high phase
  always begin
    @(posedge clock);
    #2;
    first_half = rgmii;
    @(negedge clock);
    #2;
    second_half = rgmii;
    assert (first_half.tx_en === second_half.tx_en) else begin
      $display("mismatch at %0t: rgmii.tx_en first half %b second half %b",
               $time, first_half.tx_en, second_half.tx_en);
      errors++;
    end
    if (first_half.tx_en === 1'b1) begin
      if (!in_frame) begin
        // gap only counts between two frames
        if (seen_frame) begin
          assert (gap_count >= ifg_bytes) else begin
            $display("mismatch at %0t: tx_en low gap got %0d expected at least %0d",
                     $time, gap_count, ifg_bytes);
            errors++;
          end
        end
        in_frame = 1'b1;
        cur_len  = 0;
      end
      assert (busy === 1'b1) else begin
        $display("mismatch at %0t: busy got %b expected 1 while tx_en high", $time, busy);
        errors++;
      end
      dec_bytes.push_back({second_half.tx_data, first_half.tx_data});
      cur_len++;
    end else begin
      if (in_frame) begin
        dec_lens.push_back(cur_len);
        in_frame   = 1'b0;
        seen_frame = 1'b1;
        gap_count  = 0;
      end
      gap_count++;
    end
  end

  // --------------------------------------------------------------------------
  // busy window
  // --------------------------------------------------------------------------
  // pins lag the sender by one cycle, so busy covers ifg_bytes samples after tx_en falls
  busy_through_gap: assert property (
    @(posedge clock) disable iff (reset) $fell(rgmii.tx_en) |-> busy [*ifg_bytes] ##1 !busy
  ) else begin
    $display("error at %0t: busy did not stay high for the gap and then fall", $time);
    errors++;
    busy_errors++;
  end

  busy_after_byte: assert property (
    @(posedge clock) disable iff (reset) $past(in_byte.enable) |-> busy
  ) else begin
    $display("mismatch at %0t: busy got 0 expected 1 after a frame byte", $time);
    errors++;
    busy_errors++;
  end

  // --------------------------------------------------------------------------
  // stimulus and checks
  // --------------------------------------------------------------------------
  // wait for busy low, sampled at the falling edge
  task automatic wait_idle(input string what);
    int t;
    t = 0;
    @(negedge clock);
    while (busy && t < wait_limit) begin
      @(negedge clock);
      t++;
    end
    if (busy) begin
      $display("timeout at %0t: busy stayed high before %s", $time, what);
      errors++;
    end
  endtask

  // build the expected wire image, then drive the payload one byte per clock
  task automatic send_frame(input int len);
    logic [7:0]  payload[$];
    logic [31:0] v;
    logic [31:0] crc;
    logic [7:0]  b;
    int          padded;
    for (int i = 0; i < len; i++) begin
      take_bits(8, v);
      payload.push_back(v[7:0]);
    end
    for (int i = 0; i < 7; i++) begin
      exp_bytes.push_back(8'h55);
    end
    exp_bytes.push_back(8'hD5);
    padded = (len < min_frame_bytes) ? min_frame_bytes : len;
    crc    = 32'hFFFFFFFF;
    for (int i = 0; i < padded; i++) begin
      b = (i < len) ? payload[i] : 8'h00;
      exp_bytes.push_back(b);
      crc = crc_update(crc, b);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
      exp_bytes.push_back(crc[8*i +: 8]);
    end
    exp_lens.push_back(8 + padded + 4);
    wait_idle("frame start");
    foreach (payload[i]) begin
      @(posedge clock);
      in_byte <= '{data: payload[i], enable: 1'b1};
    end
    @(posedge clock);
    in_byte <= '0;
  endtask

  // compare the next decoded frame with the next expected one
  task automatic check_frame(input string name);
    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    int         t;
    int         got_len;
    int         exp_len;
    int         n;
    logic       bad;
    string      region;
    t = 0;
    while (dec_lens.size() == 0 && t < wait_limit) begin
      @(posedge clock);
      t++;
    end
    if (dec_lens.size() == 0) begin
      $display("timeout at %0t: no frame came out on rgmii for %s", $time, name);
      errors++;
      return;
    end
    got_len = dec_lens.pop_front();
    exp_len = exp_lens.pop_front();
    assert (got_len == exp_len) else begin
      $display("mismatch at %0t: frame length of %s got %0d expected %0d",
               $time, name, got_len, exp_len);
      errors++;
    end
    for (int i = 0; i < got_len; i++) begin
      got_q.push_back(dec_bytes.pop_front());
    end
    for (int i = 0; i < exp_len; i++) begin
      exp_q.push_back(exp_bytes.pop_front());
    end
    n   = (got_len < exp_len) ? got_len : exp_len;
    bad = 1'b0;
    // first wrong byte only, the rest would follow from it
    for (int i = 0; i < n && !bad; i++) begin
      region = (i < 8) ? "preamble" : ((i >= exp_len - 4) ? "fcs" : "data");
      assert (got_q[i] === exp_q[i]) else begin
        $display("mismatch at %0t: rgmii %s byte %0d of %s got %02h expected %02h",
                 $time, region, i, name, got_q[i], exp_q[i]);
        errors++;
        bad = 1'b1;
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] crc;
    clock        = 1'b0;
    reset        = 1'b1;
    in_byte      = '0;
    lfsr         = 32'd97734;
    errors       = 0;
    busy_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    in_frame     = 1'b0;
    seen_frame   = 1'b0;
    gap_count    = 0;
    cur_len      = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // quiet pins and no busy without input
    mark = errors;
    repeat (20) begin
      @(negedge clock);
      #1;
      assert (busy === 1'b0 && rgmii.tx_en === 1'b0) else begin
        $display("mismatch at %0t: busy/tx_en got %b/%b expected 0/0",
                 $time, busy, rgmii.tx_en);
        errors++;
      end
    end
    report_test("idle after reset", mark);

    // reference model against the well known check value
    mark = errors;
    crc  = 32'hFFFFFFFF;
    for (int i = 0; i < 9; i++) begin
      crc = crc_update(crc, 8'(8'h31 + i));
    end
    assert (~crc == 32'hCBF43926) else begin
      $display("mismatch at %0t: reference crc got %08h expected cbf43926", $time, ~crc);
      errors++;
    end
    report_test("crc model", mark);

    mark = errors;
    take_bits(8, v);
    send_frame(64 + int'(v % 137));
    check_frame("long frame");
    report_test("long frame", mark);

    mark = errors;
    send_frame(1);
    check_frame("one byte frame");
    take_bits(8, v);
    send_frame(1 + int'(v % 59));
    check_frame("short frame");
    report_test("short frames", mark);

    // each start waits only for busy low, so frames follow at the minimum gap
    mark = errors;
    for (int k = 0; k < 4; k++) begin
      take_bits(8, v);
      send_frame(1 + int'(v % 200));
    end
    for (int k = 0; k < 4; k++) begin
      check_frame("back to back frame");
    end
    wait_idle("end of run");
    repeat (4) @(posedge clock);
    assert (dec_lens.size() == 0) else begin
      $display("error at %0t: rgmii carried %0d frames that were never sent",
               $time, dec_lens.size());
      errors++;
    end
    report_test("back to back", mark);

    tests_run++;
    if (busy_errors > 0) begin
      tests_failed++;
      $display("test busy window: failed with %0d errors", busy_errors);
    end else begin
      $display("test busy window: passed");
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
